/* common/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    localparam funct7_t funct7_alt = 7'b0100000; // sub / sra

    // one immediate word, read according to the instruction format
    typedef union packed {
        struct packed {
            logic [19:0]        hi;
            logic signed [11:0] off;
        } i_view;
        struct packed {
            logic [18:0] hi;
            logic [11:0] off;      // imm[12:1]
            logic        lsb;
        } b_view;
        struct packed {
            logic [19:0] upper;
            logic [11:0] lo;
        } u_view;
    } imm_u;

    typedef struct packed {
        word_t     pc;
        opcode_t   opcode;
        funct3_t   funct3;
        funct7_t   funct7;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        imm_u      imm;
    } issue_t;

    localparam logic [3:0] strb_byte = 4'b0001;
    localparam logic [3:0] strb_half = 4'b0011;
    localparam logic [3:0] strb_word = 4'b1111;

endpackage

`default_nettype wire

/* common/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    typedef enum logic [3:0] {
        cls_none,
        cls_alu,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef struct packed {
        op_class_t             op_class;
        alu_op_t               alu_op;
        logic                  use_imm;
        rv_isa_pkg::funct3_t   br_cond;    // branch funct3
        logic [3:0]            mem_strb;
        logic                  mem_signed;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::word_t     rs1_data;
        rv_isa_pkg::word_t     rs2_data;
        rv_isa_pkg::imm_u      imm;
    } dec_t;

    typedef struct packed {
        rv_isa_pkg::word_t alu_value;
        rv_isa_pkg::word_t eff_addr;
        rv_isa_pkg::word_t jump_target;
        logic              branch_taken;
    } exe_t;

    typedef struct packed {
        logic                  en;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic                  en;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     addr;
        logic [3:0]            strb;
        logic                  signed_ld;
    } mem_rd_t;

    typedef struct packed {
        logic              en;
        rv_isa_pkg::word_t addr;
        logic [3:0]        strb;
        rv_isa_pkg::word_t data;
    } mem_wr_t;

    typedef struct packed {
        logic              en;
        rv_isa_pkg::word_t target;
    } jump_t;

endpackage

`default_nettype wire

/* exec/exec_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_decode (
    input  wire logic               CLK,
    input  wire logic               reset,
    input  wire logic               flush,
    input  wire logic               stall,
    input  wire logic               mem_wait,
    input  wire rv_isa_pkg::issue_t issue,
    output exec_pkg::dec_t          dec
);

    logic                valid;
    rv_isa_pkg::issue_t  issue_q;
    rv_isa_pkg::funct3_t f3;
    logic                f7_zero;
    logic                f7_alt;

    function automatic exec_pkg::alu_op_t alu_op_of(input rv_isa_pkg::funct3_t fn,
                                                    input logic alt_sel);
        exec_pkg::alu_op_t op;
        case (fn)
            3'b000:  op = alt_sel ? exec_pkg::alu_sub : exec_pkg::alu_add;
            3'b001:  op = exec_pkg::alu_sll;
            3'b010:  op = exec_pkg::alu_slt;
            3'b011:  op = exec_pkg::alu_sltu;
            3'b100:  op = exec_pkg::alu_xor;
            3'b101:  op = alt_sel ? exec_pkg::alu_sra : exec_pkg::alu_srl;
            3'b110:  op = exec_pkg::alu_or;
            default: op = exec_pkg::alu_and;
        endcase
        return op;
    endfunction

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (mem_wait) begin
            valid <= valid;              // hold the instruction in flight
        end else begin
            valid <= !stall;             // stall inserts a bubble
        end
    end

    always_ff @(posedge CLK) begin
        if (!mem_wait) begin
            issue_q <= issue;
        end
    end

    assign f3      = issue_q.funct3;
    assign f7_zero = (issue_q.funct7 == 7'b0000000);
    assign f7_alt  = (issue_q.funct7 == rv_isa_pkg::funct7_alt);

    always_comb begin
        dec          = '0;
        dec.op_class = exec_pkg::cls_none;
        dec.alu_op   = exec_pkg::alu_add;
        dec.br_cond  = issue_q.funct3;
        dec.rd       = issue_q.rd;
        dec.pc       = issue_q.pc;
        dec.rs1_data = issue_q.rs1_data;
        dec.rs2_data = issue_q.rs2_data;
        dec.imm      = issue_q.imm;

        case (issue_q.opcode)
            rv_isa_pkg::op_reg: begin
                if (f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                    dec.op_class = exec_pkg::cls_alu;
                    dec.alu_op   = alu_op_of(f3, f7_alt);
                end
            end
            rv_isa_pkg::op_imm: begin
                // funct7 only matters for the immediate shifts
                if ((f3 != 3'b001 && f3 != 3'b101) || f7_zero || (f7_alt && f3 == 3'b101)) begin
                    dec.op_class = exec_pkg::cls_alu;
                    dec.alu_op   = alu_op_of(f3, f7_alt && f3 == 3'b101);
                    dec.use_imm  = 1'b1;
                end
            end
            rv_isa_pkg::op_lui:   dec.op_class = exec_pkg::cls_lui;
            rv_isa_pkg::op_auipc: dec.op_class = exec_pkg::cls_auipc;
            rv_isa_pkg::op_jal:   dec.op_class = exec_pkg::cls_jal;
            rv_isa_pkg::op_jalr: begin
                if (f3 == 3'b000) begin
                    dec.op_class = exec_pkg::cls_jalr;
                end
            end
            rv_isa_pkg::op_branch: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    dec.op_class = exec_pkg::cls_branch;
                end
            end
            rv_isa_pkg::op_load: begin
                dec.op_class = exec_pkg::cls_load;
                case (f3)
                    3'b000: begin
                        dec.mem_strb   = rv_isa_pkg::strb_byte;
                        dec.mem_signed = 1'b1;
                    end
                    3'b001: begin
                        dec.mem_strb   = rv_isa_pkg::strb_half;
                        dec.mem_signed = 1'b1;
                    end
                    3'b010:  dec.mem_strb = rv_isa_pkg::strb_word;
                    3'b100:  dec.mem_strb = rv_isa_pkg::strb_byte;
                    3'b101:  dec.mem_strb = rv_isa_pkg::strb_half;
                    default: dec.op_class = exec_pkg::cls_none;
                endcase
            end
            rv_isa_pkg::op_store: begin
                dec.op_class = exec_pkg::cls_store;
                case (f3)
                    3'b000:  dec.mem_strb = rv_isa_pkg::strb_byte;
                    3'b001:  dec.mem_strb = rv_isa_pkg::strb_half;
                    3'b010:  dec.mem_strb = rv_isa_pkg::strb_word;
                    default: dec.op_class = exec_pkg::cls_none;
                endcase
            end
            default: dec.op_class = exec_pkg::cls_none;
        endcase

        if (!valid) begin
            dec.op_class = exec_pkg::cls_none; // bubble
        end
    end

    a_bubble_after_reset: assert property (
        @(posedge CLK) reset |=> dec.op_class == exec_pkg::cls_none
    );

endmodule

`default_nettype wire

/* exec/exec_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_execute (
    input  wire exec_pkg::dec_t dec,
    output exec_pkg::exe_t      exe
);

    rv_isa_pkg::word_t i_off;
    rv_isa_pkg::word_t b_off;
    rv_isa_pkg::word_t u_val;
    rv_isa_pkg::word_t op_b;
    rv_isa_pkg::word_t alu_q;
    rv_isa_pkg::word_t eff_addr;
    logic              lt_s;
    logic              lt_u;
    logic              eq;

    assign i_off = {{20{dec.imm.i_view.off[11]}}, dec.imm.i_view.off};
    assign b_off = {{19{dec.imm.b_view.off[11]}}, dec.imm.b_view.off, 1'b0};
    assign u_val = {dec.imm.u_view.upper, 12'b0};

    assign op_b = dec.use_imm ? i_off : dec.rs2_data;

    // shared by slt/sltu and the branch conditions
    assign lt_s = $signed(dec.rs1_data) < $signed(op_b);
    assign lt_u = dec.rs1_data < op_b;
    assign eq   = dec.rs1_data == op_b;

    always_comb begin
        case (dec.alu_op)
            exec_pkg::alu_add:  alu_q = dec.rs1_data + op_b;
            exec_pkg::alu_sub:  alu_q = dec.rs1_data - op_b;
            exec_pkg::alu_and:  alu_q = dec.rs1_data & op_b;
            exec_pkg::alu_or:   alu_q = dec.rs1_data | op_b;
            exec_pkg::alu_xor:  alu_q = dec.rs1_data ^ op_b;
            exec_pkg::alu_sll:  alu_q = dec.rs1_data << op_b[4:0]; // shamt
            exec_pkg::alu_srl:  alu_q = dec.rs1_data >> op_b[4:0];
            exec_pkg::alu_sra:  alu_q = $signed(dec.rs1_data) >>> op_b[4:0];
            exec_pkg::alu_slt:  alu_q = {31'b0, lt_s};
            exec_pkg::alu_sltu: alu_q = {31'b0, lt_u};
            default:            alu_q = '0;
        endcase
    end

    assign eff_addr = dec.rs1_data + i_off;

    always_comb begin
        case (dec.op_class)
            exec_pkg::cls_lui:   exe.alu_value = u_val;
            exec_pkg::cls_auipc: exe.alu_value = dec.pc + u_val;
            exec_pkg::cls_jal,
            exec_pkg::cls_jalr:  exe.alu_value = dec.pc + 32'd4; // link address
            default:             exe.alu_value = alu_q;
        endcase

        exe.eff_addr = eff_addr;

        if (dec.op_class == exec_pkg::cls_jalr) begin
            exe.jump_target = {eff_addr[31:1], 1'b0};
        end else begin
            exe.jump_target = dec.pc + b_off;
        end

        case (dec.br_cond)
            3'b000:  exe.branch_taken = eq;    // beq
            3'b001:  exe.branch_taken = !eq;   // bne
            3'b100:  exe.branch_taken = lt_s;  // blt
            3'b101:  exe.branch_taken = !lt_s; // bge
            3'b110:  exe.branch_taken = lt_u;  // bltu
            3'b111:  exe.branch_taken = !lt_u; // bgeu
            default: exe.branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* exec/exec_result.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_result (
    input  wire exec_pkg::dec_t dec,
    input  wire exec_pkg::exe_t exe,
    output exec_pkg::reg_wr_t   reg_wr,
    output exec_pkg::mem_rd_t   mem_rd,
    output exec_pkg::mem_wr_t   mem_wr,
    output exec_pkg::jump_t     jump
);

    always_comb begin
        reg_wr = '0;
        mem_rd = '0;
        mem_wr = '0;
        jump   = '0;

        case (dec.op_class)
            exec_pkg::cls_alu,
            exec_pkg::cls_lui,
            exec_pkg::cls_auipc: begin
                reg_wr.en   = 1'b1;
                reg_wr.rd   = dec.rd;
                reg_wr.data = exe.alu_value;
            end
            exec_pkg::cls_jal,
            exec_pkg::cls_jalr: begin
                reg_wr.en   = 1'b1;
                reg_wr.rd   = dec.rd;
                reg_wr.data = exe.alu_value;
                jump.en     = 1'b1;
                jump.target = exe.jump_target;
            end
            exec_pkg::cls_branch: begin
                if (exe.branch_taken) begin
                    jump.en     = 1'b1;
                    jump.target = exe.jump_target;
                end
            end
            exec_pkg::cls_load: begin
                mem_rd.en        = 1'b1;
                mem_rd.rd        = dec.rd;
                mem_rd.addr      = exe.eff_addr;
                mem_rd.strb      = dec.mem_strb;
                mem_rd.signed_ld = dec.mem_signed;
            end
            exec_pkg::cls_store: begin
                mem_wr.en   = 1'b1;
                mem_wr.addr = exe.eff_addr;
                mem_wr.strb = dec.mem_strb;
                mem_wr.data = dec.rs2_data;
            end
            default: ; // bubble or unknown encoding
        endcase
    end

    // at most one of the three write-back paths per instruction
    a_one_path: assert final ($onehot0({reg_wr.en, mem_rd.en, mem_wr.en}));

    a_even_target: assert final (!jump.en || !jump.target[0]);

endmodule

`default_nettype wire

/* exec/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire logic               CLK,
    input  wire logic               reset,
    input  wire logic               flush,
    input  wire logic               stall,
    input  wire logic               mem_wait,
    input  wire rv_isa_pkg::issue_t issue,
    output exec_pkg::reg_wr_t       reg_wr,
    output exec_pkg::mem_rd_t       mem_rd,
    output exec_pkg::mem_wr_t       mem_wr,
    output exec_pkg::jump_t         jump
);

    exec_pkg::dec_t dec;
    exec_pkg::exe_t exe;

    exec_decode u_decode (
        .CLK      (CLK),
        .reset    (reset),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .issue    (issue),
        .dec      (dec)
    );

    exec_execute u_execute (
        .dec (dec),
        .exe (exe)
    );

    exec_result u_result (
        .dec    (dec),
        .exe    (exe),
        .reg_wr (reg_wr),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr),
        .jump   (jump)
    );

endmodule

`default_nettype wire

/* tb/tb_exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

    logic               CLK;
    logic               reset;
    logic               flush;
    logic               stall;
    logic               mem_wait;
    rv_isa_pkg::issue_t issue;
    exec_pkg::reg_wr_t  reg_wr;
    exec_pkg::mem_rd_t  mem_rd;
    exec_pkg::mem_wr_t  mem_wr;
    exec_pkg::jump_t    jump;

    int cycles = 0;
    int cycle_limit = 1000;
    int line_no = 0;

    // columns of the current data line
    logic [31:0] ctl_rst, ctl_flush, ctl_stall, ctl_wait;
    logic [31:0] in_pc, in_op, in_f3, in_f7, in_rd;
    logic [31:0] in_rs1, in_rs2, in_imm;
    logic [31:0] ex_mask, ex_rd, ex_a, ex_strb, ex_sgn, ex_b;

    exec_stage dut0 (
        .CLK      (CLK),
        .reset    (reset),
        .flush    (flush),
        .stall    (stall),
        .mem_wait (mem_wait),
        .issue    (issue),
        .reg_wr   (reg_wr),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr),
        .jump     (jump)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: test data not finished after %0d cycles", cycles);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    task automatic split_fields(input logic [8*256-1:0] text, output int n);
        n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    ctl_rst, ctl_flush, ctl_stall, ctl_wait,
                    in_pc, in_op, in_f3, in_f7, in_rd, in_rs1, in_rs2, in_imm,
                    ex_mask, ex_rd, ex_a, ex_strb, ex_sgn, ex_b);
    endtask

    task automatic reg_wr_check(input exec_pkg::reg_wr_t got, input exec_pkg::reg_wr_t exp);
        if (got !== exp) begin
            $display("ERR reg_wr line %0d: expected %h got %h", line_no, exp, got);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic mem_rd_check(input exec_pkg::mem_rd_t got, input exec_pkg::mem_rd_t exp);
        if (got !== exp) begin
            $display("ERR mem_rd line %0d: expected %h got %h", line_no, exp, got);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic mem_wr_check(input exec_pkg::mem_wr_t got, input exec_pkg::mem_wr_t exp);
        if (got !== exp) begin
            $display("ERR mem_wr line %0d: expected %h got %h", line_no, exp, got);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic jump_check(input exec_pkg::jump_t got, input exec_pkg::jump_t exp);
        if (got !== exp) begin
            $display("ERR jump line %0d: expected %h got %h", line_no, exp, got);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    initial begin : run_tests
        int                fd;
        int                n_fields;
        int                n_data;
        logic [8*256-1:0]  line;
        exec_pkg::reg_wr_t exp_reg;
        exec_pkg::mem_rd_t exp_ld;
        exec_pkg::mem_wr_t exp_st;
        exec_pkg::jump_t   exp_jmp;

        reset    = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        issue    = '0;

        fd = $fopen("tb/exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file tb/exec_testdata.txt");
            $display("*** FAILED ***");
            $fatal(1);
        end
        n_data = 0;
        while ($fgets(line, fd) != 0) begin
            split_fields(line, n_fields);
            if (n_fields == 18) begin
                n_data++;
            end
        end
        $fclose(fd);
        cycle_limit = n_data + 20;

        fd = $fopen("tb/exec_testdata.txt", "r");
        @(posedge CLK);
        #1;
        while ($fgets(line, fd) != 0) begin
            split_fields(line, n_fields);
            if (n_fields == 18) begin
                line_no++;
                reset          = ctl_rst[0];
                flush          = ctl_flush[0];
                stall          = ctl_stall[0];
                mem_wait       = ctl_wait[0];
                issue.pc       = in_pc;
                issue.opcode   = rv_isa_pkg::opcode_t'(in_op[6:0]);
                issue.funct3   = in_f3[2:0];
                issue.funct7   = in_f7[6:0];
                issue.rd       = in_rd[4:0];
                issue.rs1_data = in_rs1;
                issue.rs2_data = in_rs2;
                issue.imm      = in_imm;

                exp_reg = '0;
                exp_ld  = '0;
                exp_st  = '0;
                exp_jmp = '0;
                if (ex_mask[3]) begin
                    exp_reg.en   = 1'b1;
                    exp_reg.rd   = ex_rd[4:0];
                    exp_reg.data = ex_a;
                end
                if (ex_mask[2]) begin
                    exp_ld.en        = 1'b1;
                    exp_ld.rd        = ex_rd[4:0];
                    exp_ld.addr      = ex_a;
                    exp_ld.strb      = ex_strb[3:0];
                    exp_ld.signed_ld = ex_sgn[0];
                end
                if (ex_mask[1]) begin
                    exp_st.en   = 1'b1;
                    exp_st.addr = ex_a;
                    exp_st.strb = ex_strb[3:0];
                    exp_st.data = ex_b;
                end
                if (ex_mask[0]) begin
                    exp_jmp.en     = 1'b1;
                    exp_jmp.target = ex_b;
                end

                @(posedge CLK);
                #1;                          // outputs settle after the capture edge
                reg_wr_check(reg_wr, exp_reg);
                mem_rd_check(mem_rd, exp_ld);
                mem_wr_check(mem_wr, exp_st);
                jump_check(jump, exp_jmp);
            end
        end
        $fclose(fd);

        if (line_no == 0) begin
            $display("no test data lines found in tb/exec_testdata.txt");
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb/exec_testdata.txt */
// in:  reset flush stall mem_wait pc opcode funct3 funct7 rd rs1 rs2 imm
// exp: mask(reg_wr,mem_rd,mem_wr,jump) rd data_or_addr strb signed store_data_or_target
1 0 0 0 00000000 33 0 00 01 00000001 00000002 00000000  0 00 00000000 0 0 00000000
1 0 0 0 00000000 33 0 00 01 00000001 00000002 00000000  0 00 00000000 0 0 00000000
// register-register alu
0 0 0 0 00000100 33 0 00 01 00000005 00000007 00000000  8 01 0000000c 0 0 00000000
0 0 0 0 00000104 33 0 20 02 00000005 00000007 00000000  8 02 fffffffe 0 0 00000000
0 0 0 0 00000108 33 7 00 03 f0f0ff00 0ff0f0f0 00000000  8 03 00f0f000 0 0 00000000
0 0 0 0 0000010c 33 6 00 04 f0f0ff00 0ff0f0f0 00000000  8 04 fff0fff0 0 0 00000000
0 0 0 0 00000110 33 4 00 05 f0f0ff00 0ff0f0f0 00000000  8 05 ff000ff0 0 0 00000000
0 0 0 0 00000114 33 1 00 06 00000003 00000024 00000000  8 06 00000030 0 0 00000000
0 0 0 0 00000118 33 5 00 07 80000000 00000021 00000000  8 07 40000000 0 0 00000000
0 0 0 0 0000011c 33 5 20 08 80000000 00000004 00000000  8 08 f8000000 0 0 00000000
0 0 0 0 00000120 33 2 00 09 ffffffff 00000001 00000000  8 09 00000001 0 0 00000000
0 0 0 0 00000124 33 3 00 0a ffffffff 00000001 00000000  8 0a 00000000 0 0 00000000
// immediate alu
0 0 0 0 00000128 13 0 00 0b 00000010 12345678 00000ffc  8 0b 0000000c 0 0 00000000
0 0 0 0 0000012c 13 2 00 0c fffffff0 00000000 00000fff  8 0c 00000001 0 0 00000000
0 0 0 0 00000130 13 3 00 0d 00000005 00000000 00000fff  8 0d 00000001 0 0 00000000
0 0 0 0 00000134 13 5 20 0e f0000000 00000000 00000404  8 0e ff000000 0 0 00000000
// lui auipc jal jalr
0 0 0 0 00000138 37 0 00 10 00000000 00000000 12345abc  8 10 12345000 0 0 00000000
0 0 0 0 00000200 17 0 00 11 00000000 00000000 00001000  8 11 00001200 0 0 00000000
0 0 0 0 00000300 6f 0 00 01 00000000 00000000 00000010  9 01 00000304 0 0 00000310
0 0 0 0 00000400 6f 0 00 01 00000000 00000000 00001ff0  9 01 00000404 0 0 000003f0
0 0 0 0 00000500 67 0 00 05 00001001 00000000 00000008  9 05 00000504 0 0 00001008
// branches taken and not taken
0 0 0 0 00000600 63 0 00 00 00000007 00000007 00000020  1 00 00000000 0 0 00000620
0 0 0 0 00000600 63 0 00 00 00000007 00000008 00000020  0 00 00000000 0 0 00000000
0 0 0 0 00000600 63 1 00 00 00000007 00000008 00000020  1 00 00000000 0 0 00000620
0 0 0 0 00000600 63 1 00 00 00000007 00000007 00000020  0 00 00000000 0 0 00000000
0 0 0 0 00000600 63 4 00 00 ffffffff 00000001 00000020  1 00 00000000 0 0 00000620
0 0 0 0 00000600 63 4 00 00 00000001 ffffffff 00000020  0 00 00000000 0 0 00000000
0 0 0 0 00000600 63 5 00 00 00000001 ffffffff 00000020  1 00 00000000 0 0 00000620
0 0 0 0 00000600 63 5 00 00 ffffffff 00000001 00000020  0 00 00000000 0 0 00000000
0 0 0 0 00000600 63 6 00 00 00000001 ffffffff 00000020  1 00 00000000 0 0 00000620
0 0 0 0 00000600 63 6 00 00 ffffffff 00000001 00000020  0 00 00000000 0 0 00000000
0 0 0 0 00000600 63 7 00 00 ffffffff 00000001 00001ffc  1 00 00000000 0 0 000005fc
0 0 0 0 00000600 63 7 00 00 00000001 ffffffff 00001ffc  0 00 00000000 0 0 00000000
// loads and stores
0 0 0 0 00000700 03 0 00 06 00001000 00000000 00000ffc  4 06 00000ffc 1 1 00000000
0 0 0 0 00000704 03 1 00 07 00002000 00000000 00000002  4 07 00002002 3 1 00000000
0 0 0 0 00000708 03 2 00 08 00003000 00000000 00000010  4 08 00003010 f 0 00000000
0 0 0 0 0000070c 03 4 00 09 00004000 00000000 00000001  4 09 00004001 1 0 00000000
0 0 0 0 00000710 23 0 00 00 00006000 deadbeef 00000004  2 00 00006004 1 0 deadbeef
0 0 0 0 00000714 23 1 00 00 00007000 cafe1234 00000fff  2 00 00006fff 3 0 cafe1234
0 0 0 0 00000718 23 2 00 00 00008000 01234567 00000008  2 00 00008008 f 0 01234567
// stall, mem_wait and flush
0 0 1 0 00000800 33 0 00 01 00000001 00000001 00000000  0 00 00000000 0 0 00000000
0 0 0 0 00000804 33 0 00 02 00000002 00000003 00000000  8 02 00000005 0 0 00000000
0 0 0 1 00000808 33 0 20 03 00000009 00000001 00000000  8 02 00000005 0 0 00000000
0 0 0 0 00000808 33 0 20 03 00000009 00000001 00000000  8 03 00000008 0 0 00000000
0 1 0 0 0000080c 33 0 00 04 00000001 00000001 00000000  0 00 00000000 0 0 00000000
0 0 0 0 00000810 37 0 00 04 00000000 00000000 abcde000  8 04 abcde000 0 0 00000000
0 0 1 1 00000814 33 0 00 05 00000001 00000001 00000000  8 04 abcde000 0 0 00000000
0 1 0 1 00000818 33 0 00 06 00000001 00000001 00000000  0 00 00000000 0 0 00000000
// unknown encodings, then recovery
0 0 0 0 00000900 7f 0 00 07 00000001 00000001 00000fff  0 00 00000000 0 0 00000000
0 0 0 0 00000904 33 0 01 08 00000003 00000004 00000000  0 00 00000000 0 0 00000000
0 0 0 0 00000908 33 0 00 1f 7fffffff 00000001 00000000  8 1f 80000000 0 0 00000000

/* sources.f */
common/rv_isa_pkg.sv
common/exec_pkg.sv
exec/exec_decode.sv
exec/exec_execute.sv
exec/exec_result.sv
exec/exec_stage.sv
tb/tb_exec_stage.sv
